// ==== Alu.sv ====
`default_nettype none

module Alu (
  input  wire commandPkg::aluOp    op,
  input  wire commandPkg::dataWord src1,
  input  wire commandPkg::dataWord src0,
  output commandPkg::dataWord      result
);

  always_comb begin
    result = src0;
    case (op)
      4'd0: result = src1 + src0;
      4'd1: result = src1 - src0;
      4'd2: result = src1 & src0;
      4'd3: result = src1 | src0;
      4'd4: result = src1 ^ src0;
      // shift amount is the low five bits only
      4'd5: result = src1 << src0[4:0];
      4'd6: result = src1 >> src0[4:0];
      4'd7: result = src1;
      4'd8: begin
        result    = '0;
        result[0] = (src1 < src0);
      end
      default: result = src0;
    endcase
  end

endmodule

`default_nettype wire

// ==== ExecCore.sv ====
`default_nettype none

module ExecCore (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      run,
  input  wire commandPkg::dataWord memRData,
  output commandPkg::dataWord      memAddr,
  output commandPkg::dataWord      memWData,
  output logic                     memWrite,
  output logic                     instrDone
);
  import commandPkg::*;
  import seqStatePkg::*;

  seqState  state;
  cmdFields cmd;
  dataWord  condValue;

  // sequencer, one state per clock
  StateManager StateManager_inst (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .cmd       (cmd),
    .condValue (condValue),
    .state     (state),
    .instrDone (instrDone)
  );

  // registers, alu and memory port
  OperandPath OperandPath_inst (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .memRData  (memRData),
    .cmd       (cmd),
    .condValue (condValue),
    .memAddr   (memAddr),
    .memWData  (memWData),
    .memWrite  (memWrite)
  );

endmodule

`default_nettype wire

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary -j 0 -Wno-fatal --top-module tbExecCore -f sources.f -o tbExecCore
	./obj_dir/tbExecCore | tee $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG) && echo "test passed" || \
		(echo "test failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== OperandPath.sv ====
`default_nettype none

`include "core_params.svh"

module OperandPath (
  input  wire                       clk,
  input  wire                       rst,
  input  wire seqStatePkg::seqState state,
  input  wire commandPkg::dataWord  memRData,
  output commandPkg::cmdFields      cmd,
  output commandPkg::dataWord       condValue,
  output commandPkg::dataWord       memAddr,
  output commandPkg::dataWord       memWData,
  output logic                      memWrite
);
  import commandPkg::*;
  import seqStatePkg::*;

  localparam regIndex IpIdx = regIndex'(`CORE_REG_IP);

  dataWord src1Val;
  dataWord src0Val;
  dataWord dstAddr;
  dataWord result;
  dataWord aluResult;
  dataWord regData;
  dataWord stepped;
  dataWord writeData;
  regIndex readIdx;
  regIndex writeIdx;
  opFlags  updFlags;
  logic    writeEn;

  // register port select, update states read the value they modify
  always_comb begin
    readIdx  = IpIdx;
    updFlags = 2'b01;
    case (state)
      stReadCond:  readIdx = cmd.condReg;
      stReadSrc1:  readIdx = cmd.src1Reg;
      stReadSrc0:  readIdx = cmd.src0Reg;
      stReadDst:   readIdx = cmd.dstReg;
      stUpdateDst: begin
        readIdx  = cmd.dstReg;
        updFlags = cmd.dstFlags;
      end
      stWriteCond: begin
        readIdx  = cmd.condReg;
        updFlags = cmd.condFlags;
      end
      stWriteSrc1: begin
        readIdx  = cmd.src1Reg;
        updFlags = cmd.src1Flags;
      end
      stWriteSrc0: begin
        readIdx  = cmd.src0Reg;
        updFlags = cmd.src0Flags;
      end
      default: readIdx = IpIdx;
    endcase
  end

  // ip increment shares the +1 path with post-increment
  assign stepped   = (updFlags == 2'b01) ? regData + dataWord'(1) : regData - dataWord'(1);
  assign writeEn   = state inside {stWriteRegIp, stWriteDst, stUpdateDst,
                                   stWriteCond, stWriteSrc1, stWriteSrc0};
  assign writeIdx  = (state == stWriteDst) ? cmd.dstReg : readIdx;
  assign writeData = (state == stWriteDst) ? result : stepped;

  // memory port, fetch address comes straight from the ip register
  always_comb begin
    case (state)
      stReadCondP: memAddr = condValue;
      stReadSrc1P: memAddr = src1Val;
      stReadSrc0P: memAddr = src0Val;
      stWriteDstP: memAddr = dstAddr;
      default:     memAddr = regData;
    endcase
  end

  assign memWData = result;
  assign memWrite = (state == stWriteDstP);

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd <= '0;
    end else if (state == stReadCmd) begin
      cmd <= cmdFields'(memRData);
    end
  end

  // unused operands read as zero
  always_ff @(posedge clk) begin
    case (state)
      stReadCmd: begin
        condValue <= '0;
        src1Val   <= '0;
        src0Val   <= '0;
      end
      stReadCond:  condValue <= regData;
      stReadCondP: condValue <= memRData;
      stReadSrc1:  src1Val <= regData;
      stReadSrc1P: src1Val <= memRData;
      stReadSrc0:  src0Val <= regData;
      stReadSrc0P: src0Val <= memRData;
      stReadDst:   dstAddr <= regData;
      stAluBegin:  result <= aluResult;
      default: ;
    endcase
  end

  RegisterFile RegisterFile_inst (
    .clk       (clk),
    .rst       (rst),
    .readIdx   (readIdx),
    .writeIdx  (writeIdx),
    .writeEn   (writeEn),
    .writeData (writeData),
    .readData  (regData)
  );

  Alu Alu_inst (
    .op     (cmd.op),
    .src1   (src1Val),
    .src0   (src0Val),
    .result (aluResult)
  );

endmodule

`default_nettype wire

// ==== RegisterFile.sv ====
`default_nettype none

`include "core_params.svh"

module RegisterFile (
  input  wire                      clk,
  input  wire                      rst,
  input  wire commandPkg::regIndex readIdx,
  input  wire commandPkg::regIndex writeIdx,
  input  wire                      writeEn,
  input  wire commandPkg::dataWord writeData,
  output commandPkg::dataWord      readData
);
  import commandPkg::*;

  dataWord regs [`CORE_REG_COUNT];

  // all registers start at zero, ip included
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CORE_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[writeIdx] <= writeData;
    end
  end

  // read is combinational
  assign readData = regs[readIdx];

endmodule

`default_nettype wire

// ==== StateManager.sv ====
`default_nettype none

module StateManager (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   run,
  input  wire commandPkg::cmdFields cmd,
  input  wire commandPkg::dataWord  condValue,
  output seqStatePkg::seqState  state,
  output logic                  instrDone
);
  import commandPkg::*;
  import seqStatePkg::*;

  seqState nextState;
  logic    condZero;

  // read chain, order is cond, src1, src0, dst address
  function automatic seqState afterSrc0Read(cmdFields c);
    return (c.dstFlags != 2'b11 && c.dstPtr) ? stReadDst : stAluBegin;
  endfunction

  function automatic seqState afterSrc1Read(cmdFields c);
    return (c.src0Flags != 2'b11) ? stReadSrc0 : afterSrc0Read(c);
  endfunction

  function automatic seqState afterCondRead(cmdFields c);
    return (c.src1Flags != 2'b11) ? stReadSrc1 : afterSrc1Read(c);
  endfunction

  function automatic seqState firstRead(cmdFields c);
    return (c.condFlags != 2'b11) ? stReadCond : afterCondRead(c);
  endfunction

  // update chain, only flags 01 and 10 have odd parity
  function automatic seqState afterSrc1Update(cmdFields c);
    return (^c.src0Flags) ? stWriteSrc0 : stFinish;
  endfunction

  function automatic seqState afterCondUpdate(cmdFields c);
    return (^c.src1Flags) ? stWriteSrc1 : afterSrc1Update(c);
  endfunction

  function automatic seqState afterDstUpdate(cmdFields c);
    return (^c.condFlags) ? stWriteCond : afterCondUpdate(c);
  endfunction

  function automatic seqState afterDstWrite(cmdFields c);
    return (^c.dstFlags) ? stUpdateDst : afterDstUpdate(c);
  endfunction

  // condition latch is final one state after its last read
  assign condZero = (cmd.condFlags != 2'b11) && (condValue == '0);

  always_comb begin
    nextState = state;
    case (state)
      stWaitForStart, stFinish: nextState = run ? stReadCmd : stWaitForStart;
      stReadCmd:    nextState = stWriteRegIp;
      stWriteRegIp: nextState = firstRead(cmd);
      stReadCond:   nextState = cmd.condPtr ? stReadCondP : afterCondRead(cmd);
      stReadCondP:  nextState = afterCondRead(cmd);
      stReadSrc1:   nextState = cmd.src1Ptr ? stReadSrc1P : afterSrc1Read(cmd);
      stReadSrc1P:  nextState = afterSrc1Read(cmd);
      stReadSrc0:   nextState = cmd.src0Ptr ? stReadSrc0P : afterSrc0Read(cmd);
      stReadSrc0P:  nextState = afterSrc0Read(cmd);
      stReadDst:    nextState = stAluBegin;
      stAluBegin:   nextState = stAluResults;
      stAluResults: begin
        if (cmd.dstFlags != 2'b11) begin
          nextState = cmd.dstPtr ? stWriteDstP : stWriteDst;
        end else begin
          nextState = afterDstWrite(cmd);
        end
      end
      stWriteDst, stWriteDstP: nextState = afterDstWrite(cmd);
      stUpdateDst:  nextState = afterDstUpdate(cmd);
      stWriteCond:  nextState = afterCondUpdate(cmd);
      stWriteSrc1:  nextState = afterSrc1Update(cmd);
      stWriteSrc0:  nextState = stFinish;
      default:      nextState = stWaitForStart;
    endcase

    // early exit, nothing has been written yet
    if (condZero && (state inside {stReadSrc1, stReadSrc1P, stReadSrc0, stReadSrc0P,
                                   stReadDst, stAluBegin})) begin
      nextState = stFinish;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stWaitForStart;
    end else begin
      state <= nextState;
    end
  end

  assign instrDone = (state == stFinish);

endmodule

`default_nettype wire

// ==== commandPkg.sv ====
`default_nettype none

`include "core_params.svh"

package commandPkg;

  typedef logic [`CORE_DATA_W-1:0] dataWord;
  typedef logic [$clog2(`CORE_REG_COUNT)-1:0] regIndex;
  typedef logic [3:0] aluOp;

  // 00 plain, 01 post-inc, 10 post-dec, 11 operand unused
  typedef logic [1:0] opFlags;

  // command word, msb first
  typedef struct packed {
    aluOp    op;
    opFlags  condFlags;
    opFlags  dstFlags;
    opFlags  src0Flags;
    opFlags  src1Flags;
    logic    condPtr;
    logic    dstPtr;
    logic    src0Ptr;
    logic    src1Ptr;
    regIndex condReg;
    regIndex dstReg;
    regIndex src0Reg;
    regIndex src1Reg;
  } cmdFields;

endpackage

`default_nettype wire

// ==== core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define CORE_DATA_W 32

// register file depth
`define CORE_REG_COUNT 16

// instruction pointer lives in the last register
`define CORE_REG_IP 15

`endif

// ==== seqStatePkg.sv ====
`default_nettype none

package seqStatePkg;

  typedef enum logic [4:0] {
    stWaitForStart,
    // fetch and ip increment
    stReadCmd,
    stWriteRegIp,
    // operand reads, P states go through memory
    stReadCond,
    stReadCondP,
    stReadSrc1,
    stReadSrc1P,
    stReadSrc0,
    stReadSrc0P,
    stReadDst,
    stAluBegin,
    stAluResults,
    // result write
    stWriteDst,
    stWriteDstP,
    // post inc / dec updates
    stUpdateDst,
    stWriteCond,
    stWriteSrc1,
    stWriteSrc0,
    stFinish
  } seqState;

endpackage

`default_nettype wire

// ==== sources.f ====
+incdir+.
commandPkg.sv
seqStatePkg.sv
Alu.sv
RegisterFile.sv
StateManager.sv
OperandPath.sv
ExecCore.sv
tbExecCore.sv

// ==== tbRefModel.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

  typedef struct packed {
    dataWord addr;
    dataWord data;
  } memWriteRec;

  dataWord    modelRegs [`CORE_REG_COUNT];
  dataWord    modelMem [MemDepth];
  memWriteRec expWrites [$];
  dataWord    lcgState = 32'hc2ac_781d;

  // two lcg steps, upper halves only since the low bits repeat quickly
  function automatic dataWord lcgNext();
    dataWord hi;
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    hi = lcgState;
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return {hi[31:16], lcgState[31:16]};
  endfunction

  task automatic checkEqual(input dataWord actual, input dataWord expected, input string what);
    if (actual !== expected) begin
      stopOnError($sformatf("MISMATCH at time %0t: %s expected %h, got %h",
                            $time, what, expected, actual));
    end
  endtask

  function automatic dataWord modelAlu(aluOp op, dataWord s1, dataWord s0);
    case (op)
      4'd0: return s1 + s0;
      4'd1: return s1 - s0;
      4'd2: return s1 & s0;
      4'd3: return s1 | s0;
      4'd4: return s1 ^ s0;
      4'd5: return s1 << s0[4:0];
      4'd6: return s1 >> s0[4:0];
      4'd7: return s1;
      4'd8: return (s1 < s0) ? 32'd1 : 32'd0;
      default: return s0;
    endcase
  endfunction

  // unused operands read as zero, pointers go through the low address byte
  function automatic dataWord readOperand(opFlags flags, logic ptr, regIndex idx);
    if (flags == 2'b11) return 32'd0;
    if (ptr) return modelMem[modelRegs[idx][7:0]];
    return modelRegs[idx];
  endfunction

  task automatic applyUpdate(input opFlags flags, input regIndex idx);
    if (flags == 2'b01) modelRegs[idx] = modelRegs[idx] + 32'd1;
    else if (flags == 2'b10) modelRegs[idx] = modelRegs[idx] - 32'd1;
  endtask

  // one whole instruction, memory writes go to the expected queue
  task automatic stepModel();
    cmdFields   c;
    dataWord    condVal;
    dataWord    s1;
    dataWord    s0;
    memWriteRec wr;
    c = cmdFields'(modelMem[modelRegs[`CORE_REG_IP][7:0]]);
    modelRegs[`CORE_REG_IP] = modelRegs[`CORE_REG_IP] + 32'd1;
    condVal = readOperand(c.condFlags, c.condPtr, c.condReg);
    s1 = readOperand(c.src1Flags, c.src1Ptr, c.src1Reg);
    s0 = readOperand(c.src0Flags, c.src0Ptr, c.src0Reg);
    if (c.condFlags != 2'b11 && condVal == 32'd0) return;
    if (c.dstFlags != 2'b11) begin
      if (c.dstPtr) begin
        wr.addr = modelRegs[c.dstReg];
        wr.data = modelAlu(c.op, s1, s0);
        modelMem[wr.addr[7:0]] = wr.data;
        expWrites.push_back(wr);
      end else begin
        modelRegs[c.dstReg] = modelAlu(c.op, s1, s0);
      end
    end
    applyUpdate(c.dstFlags, c.dstReg);
    applyUpdate(c.condFlags, c.condReg);
    applyUpdate(c.src1Flags, c.src1Reg);
    applyUpdate(c.src0Flags, c.src0Reg);
  endtask

`endif

// ==== tbExecCore.sv ====
`default_nettype none

`include "core_params.svh"

module tbExecCore;
  import commandPkg::*;

  localparam int ClkPeriod   = 100;
  localparam int ResetCycles = 16;
  localparam int NumInstr    = 400;
  localparam int MemDepth    = 256;

  logic    clk;
  logic    rst;
  logic    run;
  dataWord memRData;
  dataWord memAddr;
  dataWord memWData;
  logic    memWrite;
  logic    instrDone;

  dataWord mem [MemDepth];
  int      doneCount;
  int      stopCount;
  int      writesChecked;
  logic    stopped;
  int      nextPause;
  int      hold;

  task automatic stopOnError(input string line);
    $display("%s", line);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  `include "tbRefModel.svh"

  // every word is a command, condition mostly unused
  function automatic dataWord randomCommand();
    cmdFields c;
    c = cmdFields'(lcgNext());
    if (lcgNext() % 4 != 0) c.condFlags = 2'b11;
    return dataWord'(c);
  endfunction

  ExecCore ExecCore_inst (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .memRData  (memRData),
    .memAddr   (memAddr),
    .memWData  (memWData),
    .memWrite  (memWrite),
    .instrDone (instrDone)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  // 256 words, low address byte only
  assign memRData = mem[memAddr[7:0]];

  always @(posedge clk) begin
    if (memWrite) mem[memAddr[7:0]] <= memWData;
  end

  // compare writes with the model, watch for activity while stopped
  always @(posedge clk) begin
    memWriteRec wr;
    if (rst) begin
      doneCount     <= 0;
      stopCount     <= 0;
      writesChecked <= 0;
      stopped       <= 1'b0;
    end else begin
      if (stopped && (instrDone || memWrite)) begin
        stopOnError("the core kept running after run went low and the instruction finished");
      end
      if (memWrite) begin
        if (expWrites.size() == 0) begin
          stopOnError("the core wrote memory where the model expects no write");
        end else begin
          wr = expWrites.pop_front();
          checkEqual(memAddr, wr.addr, "write address");
          checkEqual(memWData, wr.data, "write data");
          writesChecked <= writesChecked + 1;
        end
      end
      if (instrDone) begin
        checkEqual(dataWord'(expWrites.size()), 32'd0, "pending writes at instrDone");
        doneCount <= doneCount + 1;
        stepModel();
      end
      if (instrDone && !run) begin
        stopped   <= 1'b1;
        stopCount <= stopCount + 1;
      end else if (run) begin
        stopped <= 1'b0;
      end
    end
  end

  initial begin
    rst <= 1'b1;
    run <= 1'b0;
    for (int i = 0; i < MemDepth; i++) begin
      modelMem[i] = randomCommand();
      mem[i] <= modelMem[i];
    end
    for (int i = 0; i < `CORE_REG_COUNT; i++) begin
      modelRegs[i] = 32'd0;
    end
    // model runs one instruction ahead of the core
    stepModel();
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    run <= 1'b1;
    nextPause = 15 + int'(lcgNext() % 40);
    while (doneCount < NumInstr) begin
      @(posedge clk);
      if (doneCount >= nextPause) begin
        run <= 1'b0;
        while (!stopped) @(posedge clk);
        hold = 4 + int'(lcgNext() % 32);
        repeat (hold) @(posedge clk);
        run <= 1'b1;
        nextPause = doneCount + 15 + int'(lcgNext() % 40);
      end
    end
    if (writesChecked == 0 || stopCount == 0) begin
      stopOnError("the run saw no memory writes or never paused the core");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

  // budget of 20 cycles per instruction
  initial begin
    #((NumInstr * 20 + ResetCycles) * ClkPeriod);
    stopOnError("timeout, the core did not complete all instructions in time");
  end

endmodule

`default_nettype wire
